// File: flist.f
+incdir+include
hw/sw_pkg.sv
hw/frame_queue.sv
hw/port_tx.sv
hw/mac_table.sv
hw/forward_ctrl.sv
hw/switch_top.sv
verif/tb_switch.sv

// File: hw/forward_ctrl.sv
`timescale 1ns/1ps
`include "sw_macros.svh"

module forward_ctrl (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [`SW_PORTS-1:0]                  in_avail,
	input  logic [`SW_PORTS-1:0][`SW_DATA_W-1:0]  in_data,
	input  logic [`SW_PORTS-1:0]                  in_last,
	output logic [`SW_PORTS-1:0]                  in_rd,
	output logic                                  lk_req,
	output logic [`SW_MAC_W-1:0]                  lk_dmac,
	output logic [`SW_MAC_W-1:0]                  lk_smac,
	output logic [`SW_PORT_W-1:0]                 lk_src,
	input  logic                                  lk_ack,
	input  logic                                  lk_hit,
	input  logic [`SW_PORT_W-1:0]                 lk_port,
	input  logic [`SW_PORTS-1:0]                  eg_room,
	output sw_pkg::port_map_t                     eg_dv,
	output logic [`SW_DATA_W-1:0]                 eg_data
);

	localparam int CNT_W     = $clog2(`SW_HDR_BYTES + 1);
	localparam int MAC_BYTES = `SW_MAC_W / `SW_DATA_W;

	sw_pkg::fwd_state_t state;

	logic [`SW_PORT_W-1:0] sel;
	logic [`SW_PORT_W-1:0] last_served;
	logic [`SW_PORT_W-1:0] rr_idx;
	logic [`SW_PORT_W-1:0] rr_pick;
	logic                  rr_found;
	logic [`SW_DATA_W-1:0] hdr [`SW_HDR_BYTES];
	logic [CNT_W-1:0]      byte_cnt;
	logic [`SW_DATA_W-1:0] copy_byte;
	logic                  replay;
	logic                  rd_en;

	sw_pkg::port_map_t dest;
	sw_pkg::port_map_t src_bit;
	sw_pkg::port_map_t hit_bit;

	// round robin, starting after the last port served
	always_comb begin
		rr_found = 1'b0;
		rr_pick  = last_served;
		rr_idx   = last_served;
		for (int i = 1; i <= `SW_PORTS; i++) begin
			rr_idx = last_served + `SW_PORT_W'(i);
			if (!rr_found && in_avail[rr_idx]) begin
				rr_found = 1'b1;
				rr_pick  = rr_idx;
			end
		end
	end

	// addresses go out msb first
	always_comb begin
		for (int i = 0; i < MAC_BYTES; i++) begin
			lk_dmac[(MAC_BYTES-1-i)*`SW_DATA_W +: `SW_DATA_W] = hdr[i];
			lk_smac[(MAC_BYTES-1-i)*`SW_DATA_W +: `SW_DATA_W] = hdr[MAC_BYTES+i];
		end
	end

	assign lk_src  = sel;
	assign src_bit = sw_pkg::port_map_t'(1) << sel;
	assign hit_bit = sw_pkg::port_map_t'(1) << lk_port;

	assign replay    = (byte_cnt < `SW_HDR_BYTES);
	assign rd_en     = (state == sw_pkg::FWD_HDR) || (state == sw_pkg::FWD_COPY && !replay);
	assign in_rd     = rd_en ? src_bit : '0;
	assign copy_byte = replay ? hdr[byte_cnt] : in_data[sel];

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= sw_pkg::FWD_IDLE;
			sel         <= '0;
			last_served <= `SW_PORT_W'(`SW_PORTS - 1);   // port 0 goes first
			byte_cnt    <= '0;
			lk_req      <= 1'b0;
			dest        <= '0;
			eg_dv       <= '0;
		end else begin
			lk_req <= 1'b0;
			eg_dv  <= '0;
			case (state)
				sw_pkg::FWD_IDLE: begin
					if (rr_found) begin
						sel   <= rr_pick;
						state <= sw_pkg::FWD_HDR;
					end
				end
				sw_pkg::FWD_HDR: begin
					if (byte_cnt == CNT_W'(`SW_HDR_BYTES - 1)) begin
						byte_cnt <= '0;
						lk_req   <= 1'b1;
						state    <= sw_pkg::FWD_LOOKUP;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				sw_pkg::FWD_LOOKUP: begin
					if (lk_ack) begin
						if (!lk_hit)
							dest <= ~src_bit;           // flood
						else if (lk_port == sel)
							dest <= '0;                 // drop, still drained
						else
							dest <= hit_bit;
						state <= sw_pkg::FWD_WAIT_ROOM;
					end
				end
				sw_pkg::FWD_WAIT_ROOM: begin
					if ((eg_room & dest) == dest)
						state <= sw_pkg::FWD_COPY;
				end
				sw_pkg::FWD_COPY: begin
					eg_dv <= dest;
					if (replay) begin
						byte_cnt <= byte_cnt + 1'b1;
					end else if (in_last[sel]) begin
						byte_cnt    <= '0;
						last_served <= sel;
						state       <= sw_pkg::FWD_IDLE;
					end
				end
				default: state <= sw_pkg::FWD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == sw_pkg::FWD_HDR)
			hdr[byte_cnt] <= in_data[sel];
		if (state == sw_pkg::FWD_COPY)
			eg_data <= copy_byte;
	end

	a_ack_in_lookup: assert property (@(posedge clk) disable iff (reset)
		lk_ack |-> (state == sw_pkg::FWD_LOOKUP));

endmodule

// File: hw/frame_queue.sv
`timescale 1ns/1ps
`include "sw_macros.svh"

module frame_queue (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_dv,
	input  logic [`SW_DATA_W-1:0] in_data,
	output logic                  rx_ready,
	output logic                  avail,
	output logic [`SW_DATA_W-1:0] rd_data,
	output logic                  last,
	input  logic                  rd
);

	localparam int AW    = $clog2(`SW_QUEUE_BYTES);
	localparam int LEN_W = $clog2(`SW_MAX_FRAME + 1);
	localparam int PW    = $clog2(`SW_PTR_DEPTH);

	logic [`SW_DATA_W-1:0] buf_mem [`SW_QUEUE_BYTES];
	logic [LEN_W-1:0]      len_mem [`SW_PTR_DEPTH];

	logic [AW-1:0]    wr_addr;
	logic [AW-1:0]    rd_addr;
	logic [AW:0]      fill;
	logic [LEN_W-1:0] wr_len;
	logic [LEN_W-1:0] head_cnt;
	logic [PW-1:0]    ptr_wr;
	logic [PW-1:0]    ptr_rd;
	logic [PW:0]      ptr_cnt;
	logic             in_dv_d;
	logic             commit;
	logic             pop;
	logic             open_frame;

	assign commit     = in_dv_d && !in_dv;    // falling edge of in_dv
	assign pop        = rd && last;
	assign open_frame = (wr_len != '0);       // frame still waiting for its slot

	// room for one more full frame and a pointer slot for it
	assign rx_ready = (fill <= (`SW_QUEUE_BYTES - `SW_MAX_FRAME)) &&
		((ptr_cnt + {{PW{1'b0}}, open_frame}) < `SW_PTR_DEPTH);

	assign avail   = (ptr_cnt != '0);
	assign rd_data = buf_mem[rd_addr];
	assign last    = avail && (head_cnt == len_mem[ptr_rd] - 1'b1);

	always_ff @(posedge clk) begin
		if (in_dv)
			buf_mem[wr_addr] <= in_data;
		if (commit)
			len_mem[ptr_wr] <= wr_len;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			in_dv_d  <= 1'b0;
			wr_addr  <= '0;
			rd_addr  <= '0;
			wr_len   <= '0;
			head_cnt <= '0;
			fill     <= '0;
			ptr_wr   <= '0;
			ptr_rd   <= '0;
			ptr_cnt  <= '0;
		end else begin
			in_dv_d <= in_dv;
			if (in_dv) begin
				wr_addr <= wr_addr + 1'b1;
				wr_len  <= wr_len + 1'b1;
			end else begin
				wr_len <= '0;
			end
			if (commit)
				ptr_wr <= ptr_wr + 1'b1;

			if (rd) begin
				rd_addr  <= rd_addr + 1'b1;
				head_cnt <= pop ? '0 : head_cnt + 1'b1;
			end
			if (pop)
				ptr_rd <= ptr_rd + 1'b1;

			case ({in_dv, rd})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;
			endcase
			case ({commit, pop})
				2'b10: ptr_cnt <= ptr_cnt + 1'b1;
				2'b01: ptr_cnt <= ptr_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	a_frame_len: assert property (@(posedge clk) disable iff (reset)
		commit |-> (wr_len >= `SW_MIN_FRAME) && (wr_len <= `SW_MAX_FRAME));

	a_rd_avail: assert property (@(posedge clk) disable iff (reset)
		rd |-> avail);

endmodule

// File: hw/mac_table.sv
`timescale 1ns/1ps
`include "sw_macros.svh"

module mac_table (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  lk_req,
	input  logic [`SW_MAC_W-1:0]  lk_dmac,
	input  logic [`SW_MAC_W-1:0]  lk_smac,
	input  logic [`SW_PORT_W-1:0] lk_src,
	output logic                  lk_ack,
	output logic                  lk_hit,
	output logic [`SW_PORT_W-1:0] lk_port
);

	localparam int ENTRIES = 1 << `SW_TABLE_AW;

	logic [ENTRIES-1:0]    valid_q;
	logic [`SW_MAC_W-1:0]  mac_mem  [ENTRIES];
	logic [`SW_PORT_W-1:0] port_mem [ENTRIES];

	logic [`SW_TABLE_AW-1:0] d_idx;
	logic [`SW_TABLE_AW-1:0] s_idx;
	logic [`SW_TABLE_AW-1:0] s_idx_q;
	logic                    req_q;
	logic                    hit_q;
	logic [`SW_PORT_W-1:0]   port_q;
	logic [`SW_PORT_W-1:0]   src_q;
	logic [`SW_MAC_W-1:0]    smac_q;

	assign d_idx = sw_pkg::mac_hash(lk_dmac);
	assign s_idx = sw_pkg::mac_hash(lk_smac);

	always_ff @(posedge clk) begin
		if (reset) begin
			req_q   <= 1'b0;
			lk_ack  <= 1'b0;
			valid_q <= '0;
		end else begin
			req_q  <= lk_req;
			lk_ack <= req_q;
			if (req_q)
				valid_q[s_idx_q] <= 1'b1;
		end
	end

	// stage 1 reads the dmac entry, stage 2 answers and learns
	always_ff @(posedge clk) begin
		if (lk_req) begin
			hit_q   <= valid_q[d_idx] && (mac_mem[d_idx] == lk_dmac);
			port_q  <= port_mem[d_idx];
			smac_q  <= lk_smac;
			src_q   <= lk_src;
			s_idx_q <= s_idx;
		end
		if (req_q) begin
			lk_hit            <= hit_q;
			lk_port           <= port_q;
			mac_mem[s_idx_q]  <= smac_q;
			port_mem[s_idx_q] <= src_q;
		end
	end

	a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
		lk_req |-> !req_q);

endmodule

// File: hw/port_tx.sv
`timescale 1ns/1ps
`include "sw_macros.svh"

module port_tx (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  eg_dv,
	input  logic [`SW_DATA_W-1:0] eg_data,
	output logic                  eg_room,
	output logic                  tx_dv,
	output logic [`SW_DATA_W-1:0] tx_data
);

	sw_pkg::tx_state_t state;

	logic                  q_avail;
	logic                  q_last;
	logic                  q_rd;
	logic [`SW_DATA_W-1:0] q_data;

	frame_queue u_queue (
		.clk      (clk),
		.reset    (reset),
		.in_dv    (eg_dv),
		.in_data  (eg_data),
		.rx_ready (eg_room),
		.avail    (q_avail),
		.rd_data  (q_data),
		.last     (q_last),
		.rd       (q_rd)
	);

	assign q_rd = (state == sw_pkg::TX_SEND);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sw_pkg::TX_IDLE;
			tx_dv <= 1'b0;
		end else begin
			tx_dv <= q_rd;
			case (state)
				sw_pkg::TX_IDLE: if (q_avail) state <= sw_pkg::TX_SEND;
				sw_pkg::TX_SEND: if (q_last) state <= sw_pkg::TX_IDLE;   // gives the idle gap
				default: state <= sw_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (q_rd)
			tx_data <= q_data;
	end

endmodule

// File: hw/sw_pkg.sv
`include "sw_macros.svh"

package sw_pkg;

	typedef logic [`SW_PORTS-1:0] port_map_t;

	typedef enum logic [2:0] {
		FWD_IDLE,
		FWD_HDR,
		FWD_LOOKUP,
		FWD_WAIT_ROOM,
		FWD_COPY
	} fwd_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

	// xor of the eight 6-bit slices
	function automatic logic [`SW_TABLE_AW-1:0] mac_hash(input logic [`SW_MAC_W-1:0] mac);
		logic [`SW_TABLE_AW-1:0] h;
		h = '0;
		for (int i = 0; i < `SW_MAC_W / `SW_TABLE_AW; i++) begin
			h = h ^ mac[i*`SW_TABLE_AW +: `SW_TABLE_AW];
		end
		return h;
	endfunction

endpackage

// File: hw/switch_top.sv
`timescale 1ns/1ps
`include "sw_macros.svh"

module switch_top (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [`SW_PORTS-1:0]                  rx_dv,
	input  logic [`SW_PORTS-1:0][`SW_DATA_W-1:0]  rx_data,
	output logic [`SW_PORTS-1:0]                  rx_ready,
	output logic [`SW_PORTS-1:0]                  tx_dv,
	output logic [`SW_PORTS-1:0][`SW_DATA_W-1:0]  tx_data
);

	// ingress queues to controller
	logic [`SW_PORTS-1:0]                 q_avail;
	logic [`SW_PORTS-1:0][`SW_DATA_W-1:0] q_data;
	logic [`SW_PORTS-1:0]                 q_last;
	logic [`SW_PORTS-1:0]                 q_rd;

	// controller to table
	logic                  lk_req;
	logic [`SW_MAC_W-1:0]  lk_dmac;
	logic [`SW_MAC_W-1:0]  lk_smac;
	logic [`SW_PORT_W-1:0] lk_src;
	logic                  lk_ack;
	logic                  lk_hit;
	logic [`SW_PORT_W-1:0] lk_port;

	// controller to egress ports
	logic [`SW_PORTS-1:0]  eg_room;
	sw_pkg::port_map_t     eg_dv;
	logic [`SW_DATA_W-1:0] eg_data;

	for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
		frame_queue u_rx_queue (
			.clk      (clk),
			.reset    (reset),
			.in_dv    (rx_dv[p]),
			.in_data  (rx_data[p]),
			.rx_ready (rx_ready[p]),
			.avail    (q_avail[p]),
			.rd_data  (q_data[p]),
			.last     (q_last[p]),
			.rd       (q_rd[p])
		);

		port_tx u_port_tx (
			.clk     (clk),
			.reset   (reset),
			.eg_dv   (eg_dv[p]),
			.eg_data (eg_data),
			.eg_room (eg_room[p]),
			.tx_dv   (tx_dv[p]),
			.tx_data (tx_data[p])
		);
	end

	forward_ctrl u_forward_ctrl (
		.clk      (clk),
		.reset    (reset),
		.in_avail (q_avail),
		.in_data  (q_data),
		.in_last  (q_last),
		.in_rd    (q_rd),
		.lk_req   (lk_req),
		.lk_dmac  (lk_dmac),
		.lk_smac  (lk_smac),
		.lk_src   (lk_src),
		.lk_ack   (lk_ack),
		.lk_hit   (lk_hit),
		.lk_port  (lk_port),
		.eg_room  (eg_room),
		.eg_dv    (eg_dv),
		.eg_data  (eg_data)
	);

	mac_table u_mac_table (
		.clk     (clk),
		.reset   (reset),
		.lk_req  (lk_req),
		.lk_dmac (lk_dmac),
		.lk_smac (lk_smac),
		.lk_src  (lk_src),
		.lk_ack  (lk_ack),
		.lk_hit  (lk_hit),
		.lk_port (lk_port)
	);

endmodule

// File: include/sw_macros.svh
`ifndef SW_MACROS_SVH
`define SW_MACROS_SVH

`define SW_PORTS        4
`define SW_PORT_W       2
`define SW_DATA_W       8
`define SW_MAC_W        48

// dmac + smac
`define SW_HDR_BYTES    12
`define SW_MIN_FRAME    14
`define SW_MAX_FRAME    64

`define SW_QUEUE_BYTES  256
`define SW_PTR_DEPTH    8   // frames per queue

// 64 table entries
`define SW_TABLE_AW     6

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_switch --Mdir obj_dir -o tb_switch_sim

output=$(./obj_dir/tb_switch_sim 2>&1 || true)
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
	exit 0
fi
exit 1

// File: verif/tb_switch.sv
`timescale 1ns/1ps
`include "sw_macros.svh"

module tb_switch;

	localparam int BURST          = 80;                  // frames per port in the busy phase
	localparam int TOTAL_FRAMES   = 30 + `SW_PORTS * BURST;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (`SW_MAX_FRAME + 32) * `SW_PORTS;
	localparam int QUIET_CYCLES   = `SW_MAX_FRAME + 32;
	localparam int ENTRIES        = 1 << `SW_TABLE_AW;
	localparam logic [`SW_MAC_W-1:0] BCAST = '1;
	localparam logic [`SW_MAC_W-1:0] ROAM  = 48'h02_00_00_00_00_10;

	logic                                 clk;
	logic                                 reset;
	logic [`SW_PORTS-1:0]                 rx_dv;
	logic [`SW_PORTS-1:0][`SW_DATA_W-1:0] rx_data;
	logic [`SW_PORTS-1:0]                 rx_ready;
	logic [`SW_PORTS-1:0]                 tx_dv;
	logic [`SW_PORTS-1:0][`SW_DATA_W-1:0] tx_data;

	logic [`SW_DATA_W-1:0] frame_data [TOTAL_FRAMES][`SW_MAX_FRAME];
	int                    frame_len  [TOTAL_FRAMES];
	sw_pkg::port_map_t     exp_map    [TOTAL_FRAMES];
	int                    exp_q      [`SW_PORTS][`SW_PORTS][$];   // ids by source, dest
	int                    n_frames;
	logic [`SW_DATA_W-1:0] seq_num    [`SW_PORTS];
	logic [`SW_MAC_W-1:0]  host_mac   [`SW_PORTS];
	logic [`SW_DATA_W-1:0] mon_buf    [`SW_PORTS][`SW_MAX_FRAME];
	int                    cycles = 0;

	// reference address table
	logic                 tab_valid [ENTRIES];
	logic [`SW_MAC_W-1:0] tab_mac   [ENTRIES];
	int                   tab_port  [ENTRIES];

	switch_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.rx_dv    (rx_dv),
		.rx_data  (rx_data),
		.rx_ready (rx_ready),
		.tx_dv    (tx_dv),
		.tx_data  (tx_data)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d frames never left the switch", cycles,
				pending_frames());
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [`SW_DATA_W-1:0] got,
		input logic [`SW_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_port_map(input string name, input sw_pkg::port_map_t got,
		input sw_pkg::port_map_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_length(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [`SW_TABLE_AW-1:0] addr_index(input logic [`SW_MAC_W-1:0] mac);
		logic [`SW_TABLE_AW-1:0] idx;
		idx = '0;
		for (int s = 0; s < `SW_MAC_W; s += `SW_TABLE_AW)
			idx ^= mac[s +: `SW_TABLE_AW];
		return idx;
	endfunction

	// lookup first, then learn the source
	function automatic sw_pkg::port_map_t predict_dest(input int p,
		input logic [`SW_MAC_W-1:0] dst, input logic [`SW_MAC_W-1:0] src);
		logic [`SW_TABLE_AW-1:0] di;
		logic [`SW_TABLE_AW-1:0] si;
		sw_pkg::port_map_t       map;
		di = addr_index(dst);
		if (tab_valid[di] && tab_mac[di] == dst)
			map = (tab_port[di] == p) ? '0 : sw_pkg::port_map_t'(1) << tab_port[di];
		else
			map = ~(sw_pkg::port_map_t'(1) << p);   // flood
		si = addr_index(src);
		tab_valid[si] = 1'b1;
		tab_mac[si]   = src;
		tab_port[si]  = p;
		return map;
	endfunction

	function automatic int pending_frames();
		int n;
		n = 0;
		for (int s = 0; s < `SW_PORTS; s++)
			for (int d = 0; d < `SW_PORTS; d++)
				n += exp_q[s][d].size();
		return n;
	endfunction

	task automatic send_frame(input int p, input logic [`SW_MAC_W-1:0] dst,
		input logic [`SW_MAC_W-1:0] src);
		int id;
		int len;
		id = n_frames;
		n_frames++;
		len = `SW_MIN_FRAME + int'($urandom % (`SW_MAX_FRAME - `SW_MIN_FRAME + 1));
		for (int i = 0; i < 6; i++) begin
			frame_data[id][i]     = dst[`SW_MAC_W-1-8*i -: 8];
			frame_data[id][6 + i] = src[`SW_MAC_W-1-8*i -: 8];
		end
		frame_data[id][12] = `SW_DATA_W'(p);   // source port and sequence in the payload
		frame_data[id][13] = seq_num[p];
		seq_num[p]++;
		for (int i = 14; i < len; i++)
			frame_data[id][i] = `SW_DATA_W'($urandom);
		frame_len[id] = len;
		exp_map[id]   = predict_dest(p, dst, src);
		for (int q = 0; q < `SW_PORTS; q++)
			if (exp_map[id][q])
				exp_q[p][q].push_back(id);
		do begin
			@(posedge clk);
			#1;
		end while (!rx_ready[p]);
		for (int i = 0; i < len; i++) begin
			rx_dv[p]   = 1'b1;
			rx_data[p] = frame_data[id][i];
			@(posedge clk);
			#1;
		end
		rx_dv[p] = 1'b0;
	endtask

	task automatic burst(input int p);
		int                   pick;
		logic [`SW_MAC_W-1:0] dst;
		for (int i = 0; i < BURST; i++) begin
			pick = int'($urandom % 7);
			if (pick < `SW_PORTS)
				dst = host_mac[pick];
			else if (pick == 4)
				dst = ROAM;
			else if (pick == 5)
				dst = BCAST;
			else
				dst = {16'h0a00, 32'($urandom)};   // never learned
			send_frame(p, dst, host_mac[p]);
		end
	endtask

	// nothing expected and the tx side silent for a while
	task automatic wait_quiet();
		int idle;
		idle = 0;
		while (idle < QUIET_CYCLES) begin
			@(negedge clk);
			if (tx_dv == '0 && pending_frames() == 0)
				idle++;
			else
				idle = 0;
		end
	endtask

	task automatic collect_frame(input int p, input int len);
		int src;
		int id;
		if (len < `SW_MIN_FRAME) begin
			$display("short frame of %0d bytes on tx port %0d", len, p);
			stop_run();
		end
		src = int'(mon_buf[p][12]);
		if (src >= `SW_PORTS || exp_q[src][p].size() == 0) begin
			$display("unexpected frame on tx port %0d, payload names source %0d", p, src);
			stop_run();
		end
		id = exp_q[src][p].pop_front();
		check_length($sformatf("tx_dv[%0d] length", p), len, frame_len[id]);
		for (int i = 0; i < len; i++)
			check_byte($sformatf("tx_data[%0d] byte %0d", p, i), mon_buf[p][i], frame_data[id][i]);
	endtask

	for (genvar g = 0; g < `SW_PORTS; g++) begin : g_mon
		int cnt = 0;
		always @(negedge clk) begin
			if (tx_dv[g]) begin
				if (cnt == `SW_MAX_FRAME) begin
					$display("frame on tx port %0d runs past the maximum length", g);
					stop_run();
				end else begin
					mon_buf[g][cnt] = tx_data[g];
					cnt++;
				end
			end else if (cnt != 0) begin
				collect_frame(g, cnt);
				cnt = 0;
			end
		end
	end

	initial begin
		int p;
		int q;
		void'($urandom(32'h6d9ca282));
		reset    = 1'b1;
		rx_dv    = '0;
		rx_data  = '0;
		n_frames = 0;
		for (int i = 0; i < `SW_PORTS; i++) begin
			host_mac[i] = 48'h02_00_00_00_00_00 | `SW_MAC_W'(i);   // hashes 0x20..0x23
			seq_num[i]  = '0;
		end
		for (int i = 0; i < ENTRIES; i++)
			tab_valid[i] = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_port_map("rx_ready", rx_ready, '1);
		check_port_map("tx_dv", tx_dv, '0);

		for (int i = 0; i < `SW_PORTS; i++) begin   // broadcast, learns every host
			wait_quiet();
			send_frame(i, BCAST, host_mac[i]);
		end
		for (int i = 0; i < 12; i++) begin
			wait_quiet();
			p = int'($urandom % `SW_PORTS);
			q = (p + 1 + int'($urandom % (`SW_PORTS - 1))) % `SW_PORTS;
			send_frame(p, host_mac[q], host_mac[p]);
		end
		for (int i = 0; i < `SW_PORTS; i++) begin   // own port, dropped
			wait_quiet();
			send_frame(i, host_mac[i], host_mac[i]);
		end
		for (int i = 0; i < `SW_PORTS; i++) begin
			wait_quiet();
			send_frame(i, {16'h0a00, 32'($urandom)}, host_mac[i]);
		end
		// roaming host moves from port 1 to port 2
		wait_quiet();
		send_frame(1, BCAST, ROAM);
		wait_quiet();
		send_frame(2, BCAST, ROAM);
		for (int i = 0; i < `SW_PORTS; i++) begin
			wait_quiet();
			send_frame(i, ROAM, host_mac[i]);
		end
		wait_quiet();

		fork
			burst(0);
			burst(1);
			burst(2);
			burst(3);
		join
		wait_quiet();

		$display("Regression passed");
		$finish;
	end

endmodule
